// ==== flist.f ====
+incdir+include
verilog/symbolPkg.sv
verilog/streamPkg.sv
verilog/dcCodeTable.sv
verilog/symbolCoder.sv
verilog/bitFillCounter.sv
verilog/flushControl.sv
verilog/wordSplicer.sv
verilog/dcEntropyCoder.sv
testbench/tbDcEntropyCoder.sv

// ==== Bender.yml ====
package:
  name: dc_entropy_coder

export_include_dirs:
  - include

sources:
  - verilog/symbolPkg.sv
  - verilog/streamPkg.sv
  - verilog/dcCodeTable.sv
  - verilog/symbolCoder.sv
  - verilog/bitFillCounter.sv
  - verilog/flushControl.sv
  - verilog/wordSplicer.sv
  - verilog/dcEntropyCoder.sv
  - target: test
    files:
      - testbench/tbDcEntropyCoder.sv

// ==== testbench/tbDcEntropyCoder.sv ====
`timescale 1ns/1ps
`include "entropyConsts.svh"

module tbDcEntropyCoder
  import symbolPkg::*;
  import streamPkg::*;
;

  logic clk = 1'b0;
  logic rst_n;
  dcSymbol_t sym;
  packedWord_t out;

  // Standard JPEG DC luminance table with right-aligned codes
  int lumCode [12] = '{0, 2, 3, 4, 5, 6, 14, 30, 62, 126, 254, 510};
  int lumLen [12] = '{2, 3, 3, 3, 3, 3, 4, 5, 6, 7, 8, 9};

  bit modelBits [$];
  packedWord_t expQ [$];
  int planCats [$];
  int errorCount = 0;
  int doneCount = 0;
  int streamsSent = 0;
  int passCount = 0;
  int failCount = 0;

  dcEntropyCoder #(.chroma(0)) i_dut (.clk(clk), .rst_n(rst_n), .sym(sym), .out(out));

  always #50 clk = ~clk;

  function automatic int symLength(input int cat);
    return lumLen[cat] + cat;
  endfunction

  function automatic void appendBits(input int unsigned value, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      modelBits.push_back(value[i]);
    end
  endfunction

  // Moves count bits from the model stream into one expected word starting at the MSB
  function automatic void takeWord(input int count, input bit done);
    packedWord_t w;
    w.valid = 1'b1;
    w.done = done;
    w.size = fill_t'(count);
    w.data = '0;
    for (int i = 0; i < count; i++) begin
      w.data[`WORD_W-1-i] = modelBits.pop_front();
    end
    expQ.push_back(w);
  endfunction

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(negedge clk);
      sym = '0;
    end
  endtask

  task automatic sendSymbol(input int cat, input logic [10:0] amp, input bit last);
    @(negedge clk);
    sym.valid = 1'b1;
    sym.last = last;
    sym.category = category_t'(cat);
    sym.amplitude = amp;
    appendBits(lumCode[cat], lumLen[cat]);
    appendBits(amp, cat);  // Only the low cat bits of the amplitude
    while (modelBits.size() >= `WORD_W) takeWord(`WORD_W, 1'b0);
    if (last) begin
      takeWord(modelBits.size(), 1'b1);
      streamsSent++;
      idleCycles(2);  // Minimum gap after a stream
    end
  endtask

  task automatic sendPlanned(input int gapMax);
    int unsigned rnd;
    for (int i = 0; i < planCats.size(); i++) begin
      if (gapMax > 0) idleCycles($urandom_range(gapMax, 0));
      rnd = $urandom;
      sendSymbol(planCats[i], rnd[10:0], i == planCats.size() - 1);
    end
  endtask

  task automatic randomPlan(input int n);
    planCats.delete();
    repeat (n) planCats.push_back($urandom_range(11, 0));
  endtask

  task automatic waitDone();
    int cycles;
    cycles = 0;
    while (doneCount < streamsSent && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (doneCount < streamsSent) begin
      $display("Error: no final word arrived within 2000 cycles after stream %0d", streamsSent);
      errorCount++;
      expQ.delete();
      doneCount = streamsSent;
    end else if (expQ.size() != 0) begin
      $display("Error: the stream ended with %0d expected words never emitted", expQ.size());
      errorCount++;
      expQ.delete();
    end
  endtask

  task automatic finishTest(input string name, input int errBefore);
    if (errorCount == errBefore) begin
      passCount++;
      $display("%s: passed", name);
    end else begin
      failCount++;
      $display("%s: failed", name);
    end
  endtask

  always @(negedge clk) begin : monitor
    packedWord_t expWord;
    if (rst_n && out.valid) begin
      if (expQ.size() == 0) begin
        $display("Error at %0t ns: the DUT emitted a word that was not expected", $time);
        errorCount++;
      end else begin
        expWord = expQ.pop_front();
        if (out.data !== expWord.data) begin
          $display("Fail %0t ns out.data expected %h actual %h", $time, expWord.data, out.data);
          errorCount++;
        end
        if (out.size !== expWord.size) begin
          $display("Fail %0t ns out.size expected %0d actual %0d", $time, expWord.size, out.size);
          errorCount++;
        end
        if (out.done !== expWord.done) begin
          $display("Fail %0t ns out.done expected %b actual %b", $time, expWord.done, out.done);
          errorCount++;
        end
      end
      if (out.done) doneCount++;
    end
  end

  initial begin
    int unsigned seedSink;
    int errBefore;
    int rem;
    int c;
    int total;
    seedSink = $urandom(32'he1366199);
    sym = '0;
    rst_n = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    errBefore = errorCount;
    repeat (10) begin
      @(negedge clk);
      if (out.valid !== 1'b0) begin
        $display("Fail %0t ns out.valid expected 0 actual %b", $time, out.valid);
        errorCount++;
      end
    end
    finishTest("Idle after reset", errBefore);

    errBefore = errorCount;
    for (int cat = 0; cat < `DC_CATS; cat++) begin
      planCats.delete();
      planCats.push_back(cat);
      sendPlanned(0);
      waitDone();
    end
    finishTest("Single symbol per category", errBefore);

    errBefore = errorCount;
    repeat (8) begin
      randomPlan($urandom_range(40, 5));
      sendPlanned(0);
      waitDone();
    end
    finishTest("Random back-to-back streams", errBefore);

    // A remainder of 1 or 3 bits cannot be filled, so every step leaves 0, 2 or at least 4
    errBefore = errorCount;
    repeat (6) begin
      planCats.delete();
      rem = `WORD_W * $urandom_range(3, 1);
      while (rem > 0) begin
        c = $urandom_range(11, 0);
        if (!(rem - symLength(c) == 0 || rem - symLength(c) == 2 || rem - symLength(c) >= 4)) begin
          c = (rem >= 6) ? 0 : (rem == 5) ? 2 : (rem == 4) ? 1 : 0;
        end
        planCats.push_back(c);
        rem -= symLength(c);
      end
      sendPlanned(0);
      waitDone();
    end
    finishTest("Streams of whole words", errBefore);

    errBefore = errorCount;
    repeat (6) begin
      planCats.delete();
      total = 0;
      while (total < 45) begin
        c = $urandom_range(11, 0);
        planCats.push_back(c);
        total += symLength(c);
      end
      while (total % `WORD_W < 13) begin
        planCats.push_back(0);
        total += 2;
      end
      planCats.push_back(11);  // 20 bits always cross the word boundary here
      sendPlanned(0);
      waitDone();
    end
    finishTest("Last symbol crossing a word", errBefore);

    errBefore = errorCount;
    repeat (4) begin
      randomPlan($urandom_range(30, 5));
      sendPlanned(3);
      waitDone();
    end
    randomPlan($urandom_range(20, 5));
    sendPlanned(0);
    randomPlan($urandom_range(20, 5));
    sendPlanned(0);
    waitDone();
    finishTest("Idle gaps and minimum stream gap", errBefore);

    $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
    if (failCount == 0 && errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/dcEntropyCoder.sv ====
`timescale 1ns/1ps
`include "entropyConsts.svh"

module dcEntropyCoder
  import symbolPkg::*;
  import streamPkg::*;
#(
  parameter int chroma = 0
) (
  input logic clk,
  input logic rst_n,
  input dcSymbol_t sym,
  output packedWord_t out
);

  codedSymbol_t coded;
  fill_t shift, finalSize;
  logic fillValid, wordFull;
  spliceSel_t sel;
  logic emit, emitFinal, sizeFull;

  symbolCoder #(.chroma(chroma)) i_symbolCoder (
    .clk(clk),
    .rst_n(rst_n),
    .sym(sym),
    .coded(coded)
  );

  bitFillCounter i_bitFillCounter (
    .clk(clk),
    .rst_n(rst_n),
    .coded(coded),
    .shift(shift),
    .finalSize(finalSize),
    .fillValid(fillValid),
    .wordFull(wordFull)
  );

  flushControl i_flushControl (
    .clk(clk),
    .rst_n(rst_n),
    .codedLast(coded.last),  // Only set together with valid
    .fillValid(fillValid),
    .wordFull(wordFull),
    .sel(sel),
    .emit(emit),
    .emitFinal(emitFinal),
    .sizeFull(sizeFull)
  );

  wordSplicer i_wordSplicer (
    .clk(clk),
    .rst_n(rst_n),
    .coded(coded),
    .shift(shift),
    .finalSize(finalSize),
    .sel(sel),
    .emit(emit),
    .emitFinal(emitFinal),
    .sizeFull(sizeFull),
    .out(out)
  );

endmodule

// ==== verilog/wordSplicer.sv ====
`timescale 1ns/1ps
`include "entropyConsts.svh"

module wordSplicer
  import symbolPkg::*;
  import streamPkg::*;
(
  input logic clk,
  input logic rst_n,
  input codedSymbol_t coded,
  input fill_t shift,
  input fill_t finalSize,
  input spliceSel_t sel,
  input logic emit,
  input logic emitFinal,
  input logic sizeFull,
  output packedWord_t out
);

  word_t up, low;
  word_t partial;
  word_t splice;
  word_t shiftIn;

  logic outValid, outDone;
  word_t outData;
  fill_t outSize;

  // An idle cycle loads zeros, so up only ever holds the latest symbol
  assign shiftIn = coded.valid ? coded.code : '0;

  always_ff @(posedge clk) begin
    {up, low} <= {shiftIn, word_t'(0)} >> shift;
  end

  assign splice = partial | up;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      partial <= '0;
    end else begin
      case (sel)
        MERGE: partial <= splice;
        TAKE_LOW: partial <= low;
        TAKE_UP: partial <= up;
        CLEAR: partial <= '0;
        default: partial <= partial;  // HOLD
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outValid <= 1'b0;
      outDone <= 1'b0;
    end else begin
      outValid <= emit;
      outDone <= emit & emitFinal;
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      outData <= splice;
      outSize <= sizeFull ? fill_t'(`WORD_W) : finalSize;
    end
  end

  assign out = '{valid: outValid, done: outDone, data: outData, size: outSize};

endmodule

// ==== verilog/flushControl.sv ====
`timescale 1ns/1ps
`include "entropyConsts.svh"

module flushControl
  import streamPkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic codedLast,
  input logic fillValid,
  input logic wordFull,
  output spliceSel_t sel,
  output logic emit,
  output logic emitFinal,
  output logic sizeFull
);

  packState_t state, stateNext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= NORMAL;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    sel = HOLD;
    emit = 1'b0;
    emitFinal = 1'b0;
    sizeFull = 1'b0;
    case (state)
      NORMAL: begin
        if (fillValid) begin
          sel = MERGE;
          if (wordFull) begin
            sel = TAKE_LOW;  // Bits past the word boundary start the next word
            emit = 1'b1;
            sizeFull = 1'b1;
          end
        end
        if (codedLast) begin
          stateNext = FINAL;
        end
      end
      FINAL: begin
        emit = 1'b1;
        stateNext = NORMAL;
        if (wordFull) begin
          // The full word goes out first and the spilled bits follow next cycle
          sel = TAKE_LOW;
          sizeFull = 1'b1;
          stateNext = SPILL;
        end else begin
          sel = CLEAR;
          emitFinal = 1'b1;
        end
      end
      SPILL: begin
        emit = 1'b1;
        emitFinal = 1'b1;
        stateNext = NORMAL;
        if (fillValid) begin
          sel = TAKE_UP;
        end else begin
          sel = CLEAR;
        end
      end
      default: begin
        stateNext = NORMAL;
      end
    endcase
  end

endmodule

// ==== verilog/bitFillCounter.sv ====
`timescale 1ns/1ps
`include "entropyConsts.svh"

module bitFillCounter
  import symbolPkg::*;
  import streamPkg::*;
(
  input logic clk,
  input logic rst_n,
  input codedSymbol_t coded,
  output fill_t shift,
  output fill_t finalSize,
  output logic fillValid,
  output logic wordFull
);

  fill_t fill, fillNext, sum;
  logic overflow;

  always_comb begin
    sum = fill + fill_t'(coded.length);
    overflow = coded.valid && (sum >= `WORD_W);
    fillNext = fill;
    if (coded.valid) begin
      fillNext = overflow ? sum - fill_t'(`WORD_W) : sum;
      if (coded.last) begin
        fillNext = '0;  // Next stream starts on a fresh word
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill <= '0;
      finalSize <= '0;
      fillValid <= 1'b0;
      wordFull <= 1'b0;
    end else begin
      fill <= fillNext;
      if (coded.valid && coded.last) begin
        finalSize <= overflow ? sum - fill_t'(`WORD_W) : sum;
      end
      fillValid <= coded.valid;  // Lines up with the up/low load in the splicer
      wordFull <= overflow;
    end
  end

  assign shift = fill;

endmodule

// ==== verilog/symbolCoder.sv ====
`timescale 1ns/1ps
`include "entropyConsts.svh"

module symbolCoder
  import symbolPkg::*;
  import streamPkg::*;
#(
  parameter int chroma = 0
) (
  input logic clk,
  input logic rst_n,
  input dcSymbol_t sym,
  output codedSymbol_t coded
);

  word_t tableCode;
  codeLen_t tableLen;

  logic s1Valid, s1Last;
  category_t s1Cat;
  amplitude_t s1Amp;

  logic s2Valid, s2Last;
  word_t s2Code;
  codeLen_t s2Len;

  logic s3Valid, s3Last;
  word_t s3Code;
  codeLen_t s3Len;

  word_t ampMask;

  dcCodeTable #(.chroma(chroma)) i_dcCodeTable (
    .clk(clk),
    .lookup(sym.valid),
    .category(sym.category),
    .code(tableCode),
    .length(tableLen)
  );

  // Keeps only the low category bits of the amplitude
  assign ampMask = ~({`WORD_W{1'b1}} << s1Cat);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1Valid <= 1'b0;
      s1Last <= 1'b0;
      s2Valid <= 1'b0;
      s2Last <= 1'b0;
      s3Valid <= 1'b0;
      s3Last <= 1'b0;
    end else begin
      s1Valid <= sym.valid;
      s1Last <= sym.valid & sym.last;
      s2Valid <= s1Valid;
      s2Last <= s1Last;
      s3Valid <= s2Valid;
      s3Last <= s2Last;
    end
  end

  always_ff @(posedge clk) begin
    s1Cat <= sym.category;  // Travels beside the table read
    s1Amp <= sym.amplitude;
    s2Code <= (tableCode << s1Cat) | (word_t'(s1Amp) & ampMask);
    s2Len <= tableLen + codeLen_t'(s1Cat);
    // Length is never zero for a valid symbol, so the shift stays below WORD_W
    s3Code <= s2Code << (`WORD_W - s2Len);
    s3Len <= s2Len;
  end

  assign coded = '{valid: s3Valid, last: s3Last, code: s3Code, length: s3Len};

endmodule

// ==== verilog/dcCodeTable.sv ====
`timescale 1ns/1ps
`include "entropyConsts.svh"

module dcCodeTable
  import symbolPkg::*;
  import streamPkg::*;
#(
  parameter int chroma = 0
) (
  input logic clk,
  input logic lookup,
  input category_t category,
  output word_t code,
  output codeLen_t length
);

  localparam int ROM_CODE_W = 11;  // Longest DC code is the chroma category 11 entry
  localparam int ROM_LEN_W = 4;

  typedef struct packed {
    logic [ROM_LEN_W-1:0] len;
    logic [ROM_CODE_W-1:0] code;
  } romEntry_t;

  romEntry_t rom [`DC_CATS];

  initial begin
    if (chroma == 0) begin
      rom[0] = {4'd2, 11'b00000000000};
      rom[1] = {4'd3, 11'b00000000010};
      rom[2] = {4'd3, 11'b00000000011};
      rom[3] = {4'd3, 11'b00000000100};
      rom[4] = {4'd3, 11'b00000000101};
      rom[5] = {4'd3, 11'b00000000110};
      rom[6] = {4'd4, 11'b00000001110};
      rom[7] = {4'd5, 11'b00000011110};
      rom[8] = {4'd6, 11'b00000111110};
      rom[9] = {4'd7, 11'b00001111110};
      rom[10] = {4'd8, 11'b00011111110};
      rom[11] = {4'd9, 11'b00111111110};
    end else begin
      rom[0] = {4'd2, 11'b00000000000};
      rom[1] = {4'd2, 11'b00000000001};
      rom[2] = {4'd2, 11'b00000000010};
      rom[3] = {4'd3, 11'b00000000110};
      rom[4] = {4'd4, 11'b00000001110};
      rom[5] = {4'd5, 11'b00000011110};
      rom[6] = {4'd6, 11'b00000111110};
      rom[7] = {4'd7, 11'b00001111110};
      rom[8] = {4'd8, 11'b00011111110};
      rom[9] = {4'd9, 11'b00111111110};
      rom[10] = {4'd10, 11'b01111111110};
      rom[11] = {4'd11, 11'b11111111110};
    end
  end

  always_ff @(posedge clk) begin
    if (lookup) begin
      code <= word_t'(rom[category].code);  // Right-aligned
      length <= codeLen_t'(rom[category].len);
    end
  end

endmodule

// ==== verilog/streamPkg.sv ====
`include "entropyConsts.svh"

package streamPkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`LEN_W-1:0] fill_t;

  typedef struct packed {
    logic valid;
    logic done;    // Final word of a block stream
    word_t data;
    fill_t size;   // Number of meaningful bits from the MSB down
  } packedWord_t;

  typedef enum logic [1:0] {NORMAL, FINAL, SPILL} packState_t;

  // What the partial-word register loads on the next edge
  typedef enum logic [2:0] {HOLD, MERGE, TAKE_LOW, TAKE_UP, CLEAR} spliceSel_t;

endpackage

// ==== verilog/symbolPkg.sv ====
`include "entropyConsts.svh"

package symbolPkg;

  typedef logic [`CAT_W-1:0] category_t;
  typedef logic [10:0] amplitude_t;
  typedef logic [`LEN_W-1:0] codeLen_t;

  // One DC difference as it enters the coder
  typedef struct packed {
    logic valid;
    logic last;
    category_t category;
    amplitude_t amplitude;
  } dcSymbol_t;

  // Huffman code plus amplitude bits, left-aligned in a word
  typedef struct packed {
    logic valid;
    logic last;
    logic [`WORD_W-1:0] code;
    codeLen_t length;
  } codedSymbol_t;

endpackage

// ==== include/entropyConsts.svh ====
`ifndef ENTROPY_CONSTS_SVH
`define ENTROPY_CONSTS_SVH

// Output word width in bits
`define WORD_W 32

// Width of the DC size category field
`define CAT_W 4

// Number of DC categories in a Huffman table
`define DC_CATS 12

// Bit counts run from 0 to WORD_W inclusive
`define LEN_W 6

`endif
